// ==== src/isq_cfg.svh ====
`ifndef ISQ_CFG_SVH
`define ISQ_CFG_SVH

// queue geometry.
`define ISQ_DEPTH 8
`define ISQ_IDX_W 3

// physical register tag width.
`define PREG_W 6

// rob index bits; the rob id carries one extra wrap bit on top.
`define ROB_IDX_W 5

// immediate carried with each micro-op.
`define IMM_W 32

`endif

// ==== src/isq_pkg.sv ====
`include "isq_cfg.svh"

package isq_pkg;

    // integer alu operations.
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_e;

    typedef logic [`PREG_W-1:0]  preg_t;
    typedef logic [`ROB_IDX_W:0] robid_t;   // msb is the wrap bit.

    // renamed micro-op as held in a slot.
    typedef struct packed {
        preg_t             prs1;
        preg_t             prs2;
        logic              src1_is_reg;
        logic              src2_is_reg;
        preg_t             prd;
        logic              need_to_wb;
        logic [`IMM_W-1:0] imm;
        alu_op_e           alu_op;
        robid_t            robid;
    } uop_t;

    typedef struct packed {
        logic  valid;
        logic  need_to_wb;
        preg_t prd;
    } wb_t;

    typedef struct packed {
        logic   valid;
        robid_t robid;
    } flush_t;

endpackage

// ==== src/isq_entry.sv ====
`timescale 1ns/1ps
`include "isq_cfg.svh"

module isq_entry import isq_pkg::*; (
    input  logic   clock,
    input  logic   arst_n,
    input  logic   write,
    input  logic   clear,
    input  uop_t   wr_uop,
    input  logic   wr_src1_ready,
    input  logic   wr_src2_ready,
    input  wb_t    wb0,
    input  wb_t    wb1,
    input  flush_t flush,
    output logic   valid,
    output logic   ready_to_go,
    output uop_t   uop
);

    logic  src1_ready;
    logic  src2_ready;
    preg_t tag1;        // source tags seen by wakeup this cycle.
    preg_t tag2;
    logic  hit1;
    logic  hit2;
    logic  younger;
    logic  kill;

    function automatic logic wb_hit(wb_t wb, preg_t tag);
        return wb.valid && wb.need_to_wb && (wb.prd == tag);
    endfunction

    // an op being written can be woken in the same cycle.
    assign tag1 = write ? wr_uop.prs1 : uop.prs1;
    assign tag2 = write ? wr_uop.prs2 : uop.prs2;

    assign hit1 = wb_hit(wb0, tag1) || wb_hit(wb1, tag1);
    assign hit2 = wb_hit(wb0, tag2) || wb_hit(wb1, tag2);

    // differing wrap bits invert the index compare.
    assign younger = (flush.robid[`ROB_IDX_W] ^ uop.robid[`ROB_IDX_W]) ^
                     (flush.robid[`ROB_IDX_W-1:0] < uop.robid[`ROB_IDX_W-1:0]);
    assign kill    = valid && flush.valid && younger;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid <= 1'b0;
        end else if (kill) begin
            valid <= 1'b0;
        end else if (write) begin
            valid <= 1'b1;
        end else if (clear) begin
            valid <= 1'b0;         // issued.
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            src1_ready <= 1'b0;
            src2_ready <= 1'b0;
        end else if (write) begin
            src1_ready <= wr_src1_ready || hit1;
            src2_ready <= wr_src2_ready || hit2;
        end else begin
            src1_ready <= src1_ready || hit1;  // sticky once woken.
            src2_ready <= src2_ready || hit2;
        end
    end

    always_ff @(posedge clock) begin
        if (write) begin
            uop <= wr_uop;
        end
    end

    // immediate sources never wait.
    assign ready_to_go = valid &&
                         (src1_ready || !uop.src1_is_reg) &&
                         (src2_ready || !uop.src2_is_reg);

endmodule

// ==== src/isq_age_matrix.sv ====
`timescale 1ns/1ps
`include "isq_cfg.svh"

module isq_age_matrix (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [`ISQ_DEPTH-1:0] write,
    input  logic [`ISQ_DEPTH-1:0] valid,
    input  logic [`ISQ_DEPTH-1:0] ready,
    output logic [`ISQ_DEPTH-1:0] oldest_oh
);

    // older[i][j] is set when slot i was written before slot j.
    logic [`ISQ_DEPTH-1:0][`ISQ_DEPTH-1:0] older;
    logic [`ISQ_DEPTH-1:0]                 beaten;   // an older ready slot exists.

    // a new slot is younger than everything already held.
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            older <= '0;
        end else begin
            for (int k = 0; k < `ISQ_DEPTH; k++) begin
                if (write[k]) begin
                    for (int j = 0; j < `ISQ_DEPTH; j++) begin
                        older[j][k] <= valid[j];
                        older[k][j] <= 1'b0;   // clears the diagonal too.
                    end
                end
            end
        end
    end

    // bits of empty slots may be stale.
    // they are masked by ready and rewritten on the next fill.
    always_comb begin
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            beaten[i] = 1'b0;
            for (int j = 0; j < `ISQ_DEPTH; j++) begin
                if ((j != i) && ready[j] && older[j][i]) begin
                    beaten[i] = 1'b1;
                end
            end
        end
        oldest_oh = ready & ~beaten;
    end

endmodule

// ==== src/int_isq.sv ====
`timescale 1ns/1ps
`include "isq_cfg.svh"

module int_isq import isq_pkg::*; (
    input  logic   clock,
    input  logic   arst_n,
    input  logic   enq_valid,
    input  uop_t   enq_uop,
    input  logic   enq_src1_ready,
    input  logic   enq_src2_ready,
    output logic   enq_ready,
    output logic   issue_valid,
    input  logic   issue_ready,
    output uop_t   issue_uop,
    input  wb_t    wb0,
    input  wb_t    wb1,
    input  flush_t flush
);

    logic [`ISQ_DEPTH-1:0] slot_valid;
    logic [`ISQ_DEPTH-1:0] slot_rtg;     // ready_to_go per slot.
    uop_t                  slot_uop [`ISQ_DEPTH];
    logic [`ISQ_DEPTH-1:0] write_oh;
    logic [`ISQ_DEPTH-1:0] clear_oh;
    logic [`ISQ_DEPTH-1:0] oldest_oh;
    logic [`ISQ_IDX_W-1:0] free_idx;
    logic                  enq_fire;
    logic                  issue_fire;

    // lowest free slot, scanned from the top so the lowest wins.
    always_comb begin
        free_idx = '0;
        for (int i = `ISQ_DEPTH-1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx = `ISQ_IDX_W'(i);
            end
        end
    end

    assign enq_ready = ~&slot_valid;
    assign enq_fire  = enq_valid && enq_ready;
    assign write_oh  = enq_fire ? (`ISQ_DEPTH'(1) << free_idx) : '0;

    // nothing leaves during a flush cycle.
    assign issue_valid = (|oldest_oh) && !flush.valid;
    assign issue_fire  = issue_valid && issue_ready;
    assign clear_oh    = issue_fire ? oldest_oh : '0;

    always_comb begin
        issue_uop = '0;
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            if (oldest_oh[i]) begin
                issue_uop = slot_uop[i];
            end
        end
    end

    for (genvar g = 0; g < `ISQ_DEPTH; g++) begin : g_slot
        isq_entry entry_i (
            .clock         (clock),
            .arst_n        (arst_n),
            .write         (write_oh[g]),
            .clear         (clear_oh[g]),
            .wr_uop        (enq_uop),
            .wr_src1_ready (enq_src1_ready),
            .wr_src2_ready (enq_src2_ready),
            .wb0           (wb0),
            .wb1           (wb1),
            .flush         (flush),
            .valid         (slot_valid[g]),
            .ready_to_go   (slot_rtg[g]),
            .uop           (slot_uop[g])
        );
    end

    isq_age_matrix age_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .write     (write_oh),
        .valid     (slot_valid),
        .ready     (slot_rtg),
        .oldest_oh (oldest_oh)
    );

endmodule

// ==== dv/isq_asserts.sv ====
`timescale 1ns/1ps
`include "isq_cfg.svh"

module isq_asserts (
    input logic                  clock,
    input logic                  arst_n,
    input logic                  issue_valid,
    input logic                  enq_ready,
    input logic [`ISQ_DEPTH-1:0] slot_valid,
    input logic [`ISQ_DEPTH-1:0] oldest_oh
);

    // an issued op must come from a held slot.
    issue_from_valid_slot: assert property (
        @(posedge clock) disable iff (!arst_n)
        issue_valid |-> (|slot_valid)
    ) else $error("issue_valid high while no slot is valid");

    oldest_onehot: assert property (
        @(posedge clock) disable iff (!arst_n)
        $onehot0(oldest_oh)
    ) else $error("oldest_oh selects more than one slot");

    // full exactly when every slot is taken.
    enq_ready_full: assert property (
        @(posedge clock) disable iff (!arst_n)
        enq_ready == !(&slot_valid)
    ) else $error("enq_ready disagrees with slot occupancy");

endmodule

bind int_isq isq_asserts asserts_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .issue_valid (issue_valid),
    .enq_ready   (enq_ready),
    .slot_valid  (slot_valid),
    .oldest_oh   (oldest_oh)
);

// ==== dv/isq_tb.sv ====
`timescale 1ns/1ps
`include "isq_cfg.svh"

module isq_tb import isq_pkg::*; ();

    localparam int max_cycles = 2000;

    logic   clock = 1'b0;
    logic   arst_n;
    logic   enq_valid;
    uop_t   enq_uop;
    logic   enq_src1_ready;
    logic   enq_src2_ready;
    logic   enq_ready;
    logic   issue_valid;
    logic   issue_ready;
    uop_t   issue_uop;
    wb_t    wb0;
    wb_t    wb1;
    flush_t flush;
    int     cycles = 0;

    int_isq dut_i (
        .clock          (clock),
        .arst_n         (arst_n),
        .enq_valid      (enq_valid),
        .enq_uop        (enq_uop),
        .enq_src1_ready (enq_src1_ready),
        .enq_src2_ready (enq_src2_ready),
        .enq_ready      (enq_ready),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue_uop      (issue_uop),
        .wb0            (wb0),
        .wb1            (wb1),
        .flush          (flush)
    );

    always #4 clock = ~clock;   // 8 ns period.

    task automatic abort_run(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            abort_run("run stopped by the cycle limit");
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
            abort_run("bit mismatch");
        end
    endtask

    task automatic check_uop(input string name, input uop_t got, input uop_t exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("micro-op mismatch");
        end
    endtask

    function automatic uop_t make_uop(input preg_t rs1, input preg_t rs2, input preg_t rd,
                                      input robid_t rid);
        uop_t u;
        u.prs1        = rs1;
        u.prs2        = rs2;
        u.src1_is_reg = 1'b1;
        u.src2_is_reg = 1'b1;
        u.prd         = rd;
        u.need_to_wb  = 1'b1;
        u.imm         = $urandom;
        u.alu_op      = alu_op_e'(rid % 10);
        u.robid       = rid;
        return u;
    endfunction

    function automatic wb_t wake(input preg_t tag);
        wake = '{1'b1, 1'b1, tag};
    endfunction

    // called on a falling edge, returns on the next one.
    task automatic enqueue(input uop_t u, input logic src1_ready, input logic src2_ready);
        check_bit("enq_ready", enq_ready, 1'b1);
        enq_valid      = 1'b1;
        enq_uop        = u;
        enq_src1_ready = src1_ready;
        enq_src2_ready = src2_ready;
        @(negedge clock);
        enq_valid      = 1'b0;
        enq_src1_ready = 1'b0;
        enq_src2_ready = 1'b0;
    endtask

    task automatic drive_wb(input wb_t w0, input wb_t w1);
        wb0 = w0;
        wb1 = w1;
        @(negedge clock);
        wb0 = '0;
        wb1 = '0;
    endtask

    task automatic watch_idle(input int n);
        repeat (n) begin
            check_bit("issue_valid", issue_valid, 1'b0);
            @(negedge clock);
        end
    endtask

    // hold issue_ready low for gap cycles, then take the op.
    task automatic expect_issue(input uop_t exp, input int unsigned gap);
        int unsigned held;
        held = 0;
        while (!issue_valid) @(negedge clock);
        while (held < gap) begin
            check_uop("issue_uop", issue_uop, exp);
            @(negedge clock);
            check_bit("issue_valid", issue_valid, 1'b1);
            held++;
        end
        check_uop("issue_uop", issue_uop, exp);
        issue_ready = 1'b1;
        @(negedge clock);
        issue_ready = 1'b0;
    endtask

    task automatic reset_values();
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("enq_ready", enq_ready, 1'b1);
    endtask

    task automatic in_order_issue();
        uop_t ops [4];
        for (int i = 0; i < 4; i++) begin
            ops[i] = make_uop(preg_t'(i), preg_t'(i + 8), preg_t'(i + 16), robid_t'(i));
            enqueue(ops[i], 1'b1, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
            expect_issue(ops[i], $urandom_range(3, 1));
        end
        check_bit("issue_valid", issue_valid, 1'b0);
    endtask

    task automatic wakeup_gating();
        uop_t a;
        uop_t b;
        a = make_uop(6'd10, 6'd0, 6'd11, robid_t'(4));
        a.src2_is_reg = 1'b0;                       // immediate operand.
        enqueue(a, 1'b0, 1'b0);
        watch_idle(3);
        drive_wb('{1'b1, 1'b0, 6'd10}, '0);         // result not written back.
        watch_idle(3);
        drive_wb('0, wake(6'd10));
        expect_issue(a, 0);
        b = make_uop(6'd20, 6'd21, 6'd22, robid_t'(5));
        wb0 = wake(6'd20);                          // same cycle as the enqueue.
        enqueue(b, 1'b0, 1'b1);
        wb0 = '0;
        expect_issue(b, 0);
    endtask

    task automatic oldest_ready_first();
        uop_t ops [`ISQ_DEPTH];
        uop_t late;
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            ops[i] = make_uop(preg_t'(40 + i), 6'd0, preg_t'(50 + i), robid_t'(8 + i));
            ops[i].src2_is_reg = 1'b0;
            enqueue(ops[i], 1'b0, 1'b0);
        end
        check_bit("enq_ready", enq_ready, 1'b0);
        watch_idle(2);
        drive_wb(wake(6'd45), '0);                  // a younger op wakes first.
        expect_issue(ops[5], 0);
        late = make_uop(6'd48, 6'd0, 6'd58, robid_t'(16));
        late.src2_is_reg = 1'b0;
        enqueue(late, 1'b0, 1'b0);                  // refills slot 5 as the youngest.
        check_bit("enq_ready", enq_ready, 1'b0);
        drive_wb(wake(6'd48), wake(6'd47));
        drive_wb(wake(6'd46), wake(6'd44));
        drive_wb(wake(6'd43), wake(6'd42));
        drive_wb(wake(6'd41), wake(6'd40));
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            if (i != 5) begin
                expect_issue(ops[i], 0);
            end
        end
        expect_issue(late, 0);
        check_bit("issue_valid", issue_valid, 1'b0);
    endtask

    task automatic full_queue();
        uop_t ops [`ISQ_DEPTH];
        uop_t extra;
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            ops[i] = make_uop(preg_t'(i), preg_t'(i + 1), preg_t'(i + 24), robid_t'(16 + i));
            enqueue(ops[i], 1'b1, 1'b1);
        end
        check_bit("enq_ready", enq_ready, 1'b0);
        extra          = make_uop(6'd60, 6'd61, 6'd62, robid_t'(31));
        enq_valid      = 1'b1;   // must be dropped.
        enq_uop        = extra;
        enq_src1_ready = 1'b1;
        enq_src2_ready = 1'b1;
        repeat (2) @(negedge clock);
        enq_valid      = 1'b0;
        check_bit("enq_ready", enq_ready, 1'b0);
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            expect_issue(ops[i], 0);
        end
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("enq_ready", enq_ready, 1'b1);
    endtask

    // flush at wrap 1 index 0 keeps 30, 31 and 0x20, drops 0x21 and 0x22.
    task automatic flush_across_wrap();
        uop_t   ops [5];
        robid_t rids [5];
        rids = '{6'd30, 6'd31, 6'h20, 6'h21, 6'h22};
        for (int i = 0; i < 5; i++) begin
            ops[i] = make_uop(preg_t'(i + 2), preg_t'(i + 3), preg_t'(i + 30), rids[i]);
            enqueue(ops[i], 1'b1, 1'b1);
        end
        flush       = '{1'b1, 6'h20};
        issue_ready = 1'b1;      // nothing may leave in the flush cycle.
        #2;
        check_bit("issue_valid", issue_valid, 1'b0);
        @(negedge clock);
        flush       = '0;
        issue_ready = 1'b0;
        @(negedge clock);
        for (int i = 0; i < 3; i++) begin
            expect_issue(ops[i], $urandom_range(2, 0));
        end
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("enq_ready", enq_ready, 1'b1);
    endtask

    initial begin
        void'($urandom(9));
        arst_n         = 1'b0;
        enq_valid      = 1'b0;
        enq_uop        = '0;
        enq_src1_ready = 1'b0;
        enq_src2_ready = 1'b0;
        issue_ready    = 1'b0;
        wb0            = '0;
        wb1            = '0;
        flush          = '0;
        repeat (16) @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        reset_values();
        in_order_issue();
        wakeup_gating();
        oldest_ready_first();
        full_queue();
        flush_across_wrap();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+src
src/isq_pkg.sv
src/isq_entry.sv
src/isq_age_matrix.sv
src/int_isq.sv
dv/isq_asserts.sv
dv/isq_tb.sv
